// File: design/histPkg.sv
`default_nettype none

package histPkg;

    // sample word and coarse bin geometry
    localparam int SAMPLE_W = 12;
    localparam int BIN_W = 4;
    localparam int BIN_NUM = 1 << BIN_W;

    // bits below the coarse bin index
    localparam int FINE_SHIFT = SAMPLE_W - BIN_W;

    // per-bin counter
    localparam int COUNT_W = 8;

    // stream order within one pass
    localparam int SAMPLES_PER_PIXEL = 4;
    localparam int PIXEL_NUM = 2;
    localparam int ACQ_NUM = 2;

    // counter widths, never below one bit
    localparam int PIXEL_W = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1;
    localparam int SAMPLE_CNT_W = (SAMPLES_PER_PIXEL > 1) ? $clog2(SAMPLES_PER_PIXEL) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    // fine window spans one full histogram of one-lsb bins
    localparam int WINDOW_HALF = BIN_NUM / 2;

endpackage

`default_nettype wire

// File: design/sampleDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module sampleDecoder import histPkg::*; (
    input wire clk,
    input wire combin_res,
    input wire sampleValid,
    input wire [SAMPLE_W-1:0] sampleData,
    input wire [BIN_W-1:0] coarsePeakBin,
    output logic decValid,
    output logic [PIXEL_W-1:0] decPixel,
    output logic [BIN_W-1:0] decBin,
    output logic decHit,
    output logic decLast,
    output logic decPassEnd,
    output logic decFine
);

    // position of the incoming sample inside the pass
    logic [SAMPLE_CNT_W-1:0] sampleCnt;
    logic [PIXEL_W-1:0] pixelCnt;
    logic [ACQ_W-1:0] acqCnt;
    // low in coarse pass, high in fine pass
    logic passFine;

    // counter end flags
    logic sampleWrap;
    logic pixelWrap;
    logic acqWrap;

    // accepted sample held with its item
    logic [SAMPLE_W-1:0] sampleReg;

    // fine window of the item's pixel
    logic [SAMPLE_W-1:0] windowLow;
    logic [SAMPLE_W-1:0] fineOffset;
    logic inWindow;

    assign sampleWrap = sampleCnt == SAMPLE_CNT_W'(SAMPLES_PER_PIXEL - 1);
    assign pixelWrap = pixelCnt == PIXEL_W'(PIXEL_NUM - 1);
    assign acqWrap = acqCnt == ACQ_W'(ACQ_NUM - 1);

    // sample -> pixel -> acquisition chain
    // pass flips after the last acquisition
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            passFine <= 1'b0;
        end else if (sampleValid) begin
            if (!sampleWrap) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                if (!pixelWrap) begin
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    pixelCnt <= '0;
                    if (!acqWrap) begin
                        acqCnt <= acqCnt + 1'b1;
                    end else begin
                        acqCnt <= '0;
                        passFine <= !passFine;
                    end
                end
            end
        end
    end

    // item flags pulse only for accepted samples
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            decValid <= 1'b0;
            decLast <= 1'b0;
            decPassEnd <= 1'b0;
            decFine <= 1'b0;
        end else begin
            decValid <= sampleValid;
            // last sample of a pixel in the final acquisition
            decLast <= sampleValid && sampleWrap && acqWrap;
            decPassEnd <= sampleValid && sampleWrap && pixelWrap && acqWrap;
            if (sampleValid) begin
                decFine <= passFine;
            end
        end
    end

    // item payload
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            sampleReg <= sampleData;
            decPixel <= pixelCnt;
        end
    end

    // coarse peak scaled up and centred on the middle of that coarse bin
    assign windowLow = (SAMPLE_W'(coarsePeakBin) << FINE_SHIFT)
                     + SAMPLE_W'(1 << (FINE_SHIFT - 1))
                     - SAMPLE_W'(WINDOW_HALF);
    assign fineOffset = sampleReg - windowLow;
    // offset only meaningful once sample is at or above the bound
    assign inWindow = (sampleReg >= windowLow)
                   && (fineOffset <= SAMPLE_W'(2 * WINDOW_HALF - 1));

    // bin select per pass
    always_comb begin
        if (decFine) begin
            decBin = inWindow ? fineOffset[BIN_W-1:0] : '0;
            decHit = inWindow;
        end else begin
            // coarse bin is the top of the word
            decBin = sampleReg[SAMPLE_W-1 -: BIN_W];
            decHit = 1'b1;
        end
    end

    // pass end item belongs to the last pixel of the last acquisition
    passEndOnLastPixel: assert property (
        @(posedge clk) disable iff (!combin_res)
            decPassEnd |-> decLast && (decPixel == PIXEL_W'(PIXEL_NUM - 1))
    );

endmodule

`default_nettype wire

// File: design/binAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

module binAccumulator import histPkg::*; (
    input wire clk,
    input wire combin_res,
    input wire decValid,
    input wire [PIXEL_W-1:0] decPixel,
    input wire [BIN_W-1:0] decBin,
    input wire decHit,
    input wire decLast,
    input wire decPassEnd,
    input wire decFine,
    output logic accValid,
    output logic [PIXEL_W-1:0] accPixel,
    output logic [BIN_W-1:0] accBin,
    output logic accHit,
    output logic accLast,
    output logic accPassEnd,
    output logic accFine,
    output logic [COUNT_W-1:0] accCount
);

    // one histogram per pixel
    logic [COUNT_W-1:0] countMem [PIXEL_NUM][BIN_NUM];
    // cleared bit marks the bin empty, whatever countMem still holds
    logic [BIN_NUM-1:0] binValid [PIXEL_NUM];

    // read side of the addressed bin
    logic [COUNT_W-1:0] curCount;
    logic curValid;
    logic [COUNT_W-1:0] newCount;
    logic doCount;

    assign doCount = decValid && decHit;
    assign curCount = countMem[decPixel][decBin];
    assign curValid = binValid[decPixel][decBin];
    // first hit after a clear restarts at one
    assign newCount = curValid ? curCount + 1'b1 : COUNT_W'(1);

    // valid bits, whole table cleared at pass end
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                binValid[p] <= '0;
            end
        end else begin
            if (doCount) begin
                binValid[decPixel][decBin] <= 1'b1;
            end
            // clear wins over the set of the final sample
            if (decValid && decPassEnd) begin
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    binValid[p] <= '0;
                end
            end
        end
    end

    // count storage
    always_ff @(posedge clk) begin
        if (doCount) begin
            countMem[decPixel][decBin] <= newCount;
        end
    end

    // item flags forwarded one stage
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            accValid <= 1'b0;
            accHit <= 1'b0;
            accLast <= 1'b0;
            accPassEnd <= 1'b0;
        end else begin
            accValid <= decValid;
            accHit <= doCount;
            accLast <= decValid && decLast;
            accPassEnd <= decValid && decPassEnd;
        end
    end

    // item payload with the updated count
    always_ff @(posedge clk) begin
        if (decValid) begin
            accPixel <= decPixel;
            accBin <= decBin;
            accFine <= decFine;
            accCount <= decHit ? newCount : '0;
        end
    end

    // a counted sample never leaves a zero count behind
    noCountWrap: assert property (
        @(posedge clk) disable iff (!combin_res) doCount |=> (accCount != '0)
    );

endmodule

`default_nettype wire

// File: design/peakTracker.sv
`timescale 1ns/1ps
`default_nettype none

module peakTracker import histPkg::*; (
    input wire clk,
    input wire combin_res,
    input wire accValid,
    input wire [PIXEL_W-1:0] accPixel,
    input wire [BIN_W-1:0] accBin,
    input wire accHit,
    input wire accLast,
    input wire accPassEnd,
    input wire accFine,
    input wire [COUNT_W-1:0] accCount,
    input wire [PIXEL_W-1:0] decPixel,
    output logic [BIN_W-1:0] coarsePeakBin,
    output logic peakValid,
    output logic [PIXEL_W-1:0] peakPixel,
    output logic peakFine,
    output logic [BIN_W-1:0] peakBin
);

    // running maximum and its bin, per pixel
    logic [COUNT_W-1:0] runMax [PIXEL_NUM];
    logic [BIN_W-1:0] runBin [PIXEL_NUM];
    // coarse peaks kept for the following fine pass
    logic [BIN_W-1:0] coarseTable [PIXEL_NUM];

    logic newMax;
    logic [BIN_W-1:0] bestBin;
    logic reportNow;

    // strict compare, so a tie keeps the bin that got there first
    assign newMax = accValid && accHit && (accCount > runMax[accPixel]);
    // peak including the current item
    assign bestBin = newMax ? accBin : runBin[accPixel];
    assign reportNow = accValid && accLast;

    // window source for the item sitting in the decoder
    assign coarsePeakBin = coarseTable[decPixel];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                runMax[p] <= '0;
                runBin[p] <= '0;
                coarseTable[p] <= '0;
            end
        end else begin
            // coarse result latched for the fine window
            if (reportNow && !accFine) begin
                coarseTable[accPixel] <= bestBin;
            end
            if (accValid && accPassEnd) begin
                // fresh maxima for every pixel in the next pass
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    runMax[p] <= '0;
                    runBin[p] <= '0;
                end
            end else if (reportNow) begin
                // pixel done for this pass, empty pixel reports bin 0 next time
                runMax[accPixel] <= '0;
                runBin[accPixel] <= '0;
            end else if (newMax) begin
                runMax[accPixel] <= accCount;
                runBin[accPixel] <= accBin;
            end
        end
    end

    // report strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= reportNow;
        end
    end

    // report payload
    always_ff @(posedge clk) begin
        if (reportNow) begin
            peakPixel <= accPixel;
            peakFine <= accFine;
            peakBin <= bestBin;
        end
    end

    // reports are separated by at least one pixel's worth of samples
    singleReport: assert property (
        @(posedge clk) disable iff (!combin_res) peakValid |=> !peakValid
    );

endmodule

`default_nettype wire

// File: design/histPeakFinder.sv
`timescale 1ns/1ps
`default_nettype none

module histPeakFinder import histPkg::*; (
    input wire clk,
    input wire combin_res,
    input wire sampleValid,
    input wire [SAMPLE_W-1:0] sampleData,
    output logic peakValid,
    output logic [PIXEL_W-1:0] peakPixel,
    output logic peakFine,
    output logic [BIN_W-1:0] peakBin
);

    // decoder item
    logic decValid;
    logic [PIXEL_W-1:0] decPixel;
    logic [BIN_W-1:0] decBin;
    logic decHit;
    logic decLast;
    logic decPassEnd;
    logic decFine;

    // accumulator item
    logic accValid;
    logic [PIXEL_W-1:0] accPixel;
    logic [BIN_W-1:0] accBin;
    logic accHit;
    logic accLast;
    logic accPassEnd;
    logic accFine;
    logic [COUNT_W-1:0] accCount;

    // coarse peak fed back for the fine window
    logic [BIN_W-1:0] coarsePeakBin;

    sampleDecoder i_decoder (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sampleData(sampleData),
        .coarsePeakBin(coarsePeakBin),
        .decValid(decValid),
        .decPixel(decPixel),
        .decBin(decBin),
        .decHit(decHit),
        .decLast(decLast),
        .decPassEnd(decPassEnd),
        .decFine(decFine)
    );

    binAccumulator i_accumulator (
        .clk(clk),
        .combin_res(combin_res),
        .decValid(decValid),
        .decPixel(decPixel),
        .decBin(decBin),
        .decHit(decHit),
        .decLast(decLast),
        .decPassEnd(decPassEnd),
        .decFine(decFine),
        .accValid(accValid),
        .accPixel(accPixel),
        .accBin(accBin),
        .accHit(accHit),
        .accLast(accLast),
        .accPassEnd(accPassEnd),
        .accFine(accFine),
        .accCount(accCount)
    );

    peakTracker i_tracker (
        .clk(clk),
        .combin_res(combin_res),
        .accValid(accValid),
        .accPixel(accPixel),
        .accBin(accBin),
        .accHit(accHit),
        .accLast(accLast),
        .accPassEnd(accPassEnd),
        .accFine(accFine),
        .accCount(accCount),
        .decPixel(decPixel),
        .coarsePeakBin(coarsePeakBin),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakFine(peakFine),
        .peakBin(peakBin)
    );

endmodule

`default_nettype wire

// File: sim/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic combin_res
);

    // free-running clock, 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset low for the first 10 rising edges
    initial begin
        combin_res = 1'b0;
        repeat (10) @(posedge clk);
        // release away from the edge
        #1;
        combin_res = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/histPeakFinderTb.sv
`timescale 1ns/1ps
`default_nettype none

module histPeakFinderTb import histPkg::*; ();

    // DUT ports
    logic clk;
    logic combin_res;
    logic sampleValid;
    logic [SAMPLE_W-1:0] sampleData;
    logic peakValid;
    logic [PIXEL_W-1:0] peakPixel;
    logic peakFine;
    logic [BIN_W-1:0] peakBin;

    // stream and expected reports, in file order
    logic [SAMPLE_W-1:0] sampleQueue [$];
    logic [PIXEL_W-1:0] expPixelQueue [$];
    logic expFineQueue [$];
    logic [BIN_W-1:0] expBinQueue [$];

    // idle cycle source
    integer seed;

    clockGen i_clockGen (
        .clk(clk),
        .combin_res(combin_res)
    );

    histPeakFinder i_dut (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sampleData(sampleData),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakFine(peakFine),
        .peakBin(peakBin)
    );

    task automatic stopOnFailure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic reportProblem(input string text);
        $display("%s", text);
        stopOnFailure();
    endtask

    task automatic reportMismatch(input string testName, input string field,
                                  input int expected, input int actual);
        $display("mismatch %s %s expected 0x%0h actual 0x%0h",
                 testName, field, expected, actual);
        stopOnFailure();
    endtask

    // S lines carry samples, P lines expected reports, # lines are notes
    task automatic loadTestData();
        int fd;
        int code;
        bit done;
        logic [63:0] tag;
        logic [1023:0] restOfLine;
        logic [SAMPLE_W-1:0] sampleWord;
        int pixelField;
        int passField;
        int binField;
        fd = $fopen("sim/testdata.txt", "r");
        if (fd == 0) begin
            reportProblem("could not open sim/testdata.txt for reading");
        end else begin
            done = 1'b0;
            while (!done) begin
                tag = '0;
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "S") begin
                    code = $fscanf(fd, "%h", sampleWord);
                    sampleQueue.push_back(sampleWord);
                end else if (tag == "P") begin
                    code = $fscanf(fd, "%d %d %h", pixelField, passField, binField);
                    expPixelQueue.push_back(PIXEL_W'(pixelField));
                    expFineQueue.push_back(passField != 0);
                    expBinQueue.push_back(BIN_W'(binField));
                end else if (tag == "#") begin
                    code = $fgets(restOfLine, fd);
                end else begin
                    reportProblem("unknown record type in sim/testdata.txt");
                end
            end
            $fclose(fd);
            if (sampleQueue.size() == 0 || expBinQueue.size() == 0) begin
                reportProblem("sim/testdata.txt holds no samples or no expected reports");
            end
        end
    endtask

    task automatic waitForReset();
        int waited;
        waited = 0;
        while (!combin_res && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!combin_res) begin
            reportProblem("reset was never released");
        end
    endtask

    // peakValid looked at mid-cycle, one pulse per call
    task automatic waitForPeak(input int index);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!peakValid && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!peakValid) begin
            reportProblem($sformatf("no peak report %0d within 200 cycles", index));
        end
    endtask

    // 0 to 3 idle cycles ahead of each sample
    task automatic driveSamples();
        int idle;
        for (int n = 0; n < sampleQueue.size(); n++) begin
            idle = $unsigned($random(seed)) % 4;
            repeat (idle) begin
                @(posedge clk);
                #1;
                sampleValid = 1'b0;
            end
            @(posedge clk);
            #1;
            sampleValid = 1'b1;
            sampleData = sampleQueue[n];
        end
        @(posedge clk);
        #1;
        sampleValid = 1'b0;
    endtask

    // reports must come in file order
    task automatic checkPeaks();
        string testName;
        for (int n = 0; n < expBinQueue.size(); n++) begin
            waitForPeak(n);
            testName = $sformatf("report %0d pixel %0d %s", n, expPixelQueue[n],
                                 expFineQueue[n] ? "fine" : "coarse");
            assert (peakPixel == expPixelQueue[n]) else begin
                reportMismatch(testName, "pixel", int'(expPixelQueue[n]), int'(peakPixel));
            end
            assert (peakFine == expFineQueue[n]) else begin
                reportMismatch(testName, "pass", int'(expFineQueue[n]), int'(peakFine));
            end
            assert (peakBin == expBinQueue[n]) else begin
                reportMismatch(testName, "bin", int'(expBinQueue[n]), int'(peakBin));
            end
        end
    endtask

    // no stray report once the stream has drained
    task automatic checkQuiet();
        repeat (20) begin
            @(negedge clk);
            assert (!peakValid) else begin
                reportProblem("peak report seen after the last expected one");
            end
        end
    endtask

    initial begin
        sampleValid = 1'b0;
        sampleData = '0;
        seed = 81;
        loadTestData();
        waitForReset();
        fork
            driveSamples();
            checkPeaks();
        join
        checkQuiet();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
design/histPkg.sv
design/sampleDecoder.sv
design/binAccumulator.sv
design/peakTracker.sv
design/histPeakFinder.sv
sim/clockGen.sv
sim/histPeakFinderTb.sv

// File: Makefile
# Verilator build and run of the histogram peak finder testbench

VERILATOR ?= verilator
TOP ?= histPeakFinderTb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
RUN_ARGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exit status carries pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/testdata.txt
# S hhh gives one sample in hex, in stream order of acquisition, pixel, sample
# P pixel pass bin gives an expected report, pass 0 is coarse and 1 is fine, bin in hex
S 7B0
S 350
S 7C0
S 3A0
S A10
S A80
S 5F0
S AFF
S 3FF
S 720
S 123
S 9E0
P 0 0 3
S 200
S A44
S 5AA
S 0FF
P 1 0 A
S 380
S 37F
S 380
S 377
S A10
S A77
S A88
S B00
S 388
S 37F
S 37F
S 387
P 0 1 7
S 000
S FFF
S A70
S 590
P 1 1 0
S 3F0
S C00
S C11
S 7AA
S 5A0
S 6B0
S 6C0
S 5D0
S E01
S C22
S 7BB
S E02
P 0 0 C
S A00
S 6FF
S 5EE
S 500
P 1 0 5
S C80
S C81
S C81
S C7A
S 587
S 578
S 583
S 583
S C7A
S C7A
S D00
S C81
P 0 1 2
S 587
S 587
S 583
S 600
P 1 1 F
